/* design/sld_consts.svh */
// slide unit constants
// datapath geometry and APB register offsets
`ifndef SLD_CONSTS_SVH
`define SLD_CONSTS_SVH

// vector register and beat geometry
`define SLD_VREG_W 128
`define SLD_OP_W   32
`define SLD_VMSK_W 16
`define SLD_BEATS  4

// vector length in elements, 0 to 16
`define SLD_VL_W   5

// APB address width and byte offsets
`define SLD_APB_AW     4
`define SLD_REG_CTRL   4'h0
`define SLD_REG_SCALAR 4'h4
`define SLD_REG_VL     4'h8
`define SLD_REG_STATUS 4'hC

`endif

/* design/sld_pkg.sv */
// slide unit types
// opcodes, element widths, FSM states and the beat and lane records
`include "sld_consts.svh"

package sld_pkg;

    typedef enum logic [1:0] {
        SLD_UP    = 2'd0,
        SLD_DOWN  = 2'd1,
        SLD_1UP   = 2'd2,
        SLD_1DOWN = 2'd3
    } sld_op_e;

    // code 2'b11 is reserved
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sld_sew_e;

    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_RUN  = 1'b1
    } sld_fetch_state_e;

    // one operand beat: word pair, byte offset into it and word validity
    typedef struct packed {
        logic [`SLD_OP_W-1:0] lo;
        logic [`SLD_OP_W-1:0] hi;
        logic [1:0]           offset;
        logic                 lo_valid;
        logic                 hi_valid;
        logic [1:0]           idx;
        sld_sew_e             sew;
        logic [`SLD_VL_W-1:0] vl;
    } sld_beat_t;

    // one result beat
    typedef struct packed {
        logic [`SLD_OP_W-1:0] data;
        logic [3:0]           mask;
        logic [1:0]           idx;
        sld_sew_e             sew;
        logic [`SLD_VL_W-1:0] vl;
    } sld_lane_t;

    // element size in bytes
    function automatic logic [2:0] sld_esize(input sld_sew_e sew);
        return 3'd1 << sew;
    endfunction

    // vector length in bytes
    function automatic logic [6:0] sld_vl_bytes(input logic [`SLD_VL_W-1:0] vl,
                                                input sld_sew_e sew);
        return 7'(vl) << sew;
    endfunction

endpackage

/* design/sld_cfg_if.sv */
// slide unit configuration link
// carries the programmed setup from the register block to the datapath
`include "sld_consts.svh"

interface sld_cfg_if
    import sld_pkg::*;
();

    sld_op_e              op;
    sld_sew_e             sew;
    logic [31:0]          amount;
    logic [31:0]          scalar;
    logic [`SLD_VL_W-1:0] vl;
    // high while a vector is being fetched
    logic                 busy;

    modport regs (
        output op, sew, amount, scalar, vl,
        input  busy
    );

    modport engine (
        input  op, sew, amount, scalar, vl,
        output busy
    );

endinterface

/* design/sld_apb_regs.sv */
// slide unit register block
// APB slave with CTRL, SCALAR, VL and a read-only STATUS register
`include "sld_consts.svh"

module sld_apb_regs
    import sld_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  logic [`SLD_APB_AW-1:0] paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    input  logic                   result_done_i,
    sld_cfg_if.regs                cfg
);

    sld_op_e              op_q;
    sld_sew_e             sew_q;
    logic [31:0]          scalar_q;
    logic [`SLD_VL_W-1:0] vl_q;
    logic [7:0]           done_cnt_q;
    logic                 wr_en;

    // no wait states
    assign pready_o  = psel_i & penable_i;
    assign pslverr_o = 1'b0;
    assign wr_en     = psel_i & penable_i & pwrite_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            op_q       <= SLD_UP;
            sew_q      <= SEW_8;
            scalar_q   <= '0;
            vl_q       <= '0;
            done_cnt_q <= '0;
        end else begin
            if (wr_en) begin
                case (paddr_i)
                    `SLD_REG_CTRL: begin
                        op_q <= sld_op_e'(pwdata_i[1:0]);
                        // reserved width code leaves sew untouched
                        if (pwdata_i[3:2] != 2'b11) begin
                            sew_q <= sld_sew_e'(pwdata_i[3:2]);
                        end
                    end
                    `SLD_REG_SCALAR: scalar_q <= pwdata_i;
                    `SLD_REG_VL:     vl_q     <= pwdata_i[`SLD_VL_W-1:0];
                    default: ;
                endcase
            end
            if (result_done_i) begin
                done_cnt_q <= done_cnt_q + 8'd1;
            end
        end
    end

    always_comb begin
        case (paddr_i)
            `SLD_REG_CTRL:   prdata_o = {28'd0, sew_q, op_q};
            `SLD_REG_SCALAR: prdata_o = scalar_q;
            `SLD_REG_VL:     prdata_o = {{(32-`SLD_VL_W){1'b0}}, vl_q};
            `SLD_REG_STATUS: prdata_o = {16'd0, done_cnt_q, 7'd0, cfg.busy};
            default:         prdata_o = '0;
        endcase
    end

    // SCALAR is also the slide amount, like rs1 of the vector slide instructions
    assign cfg.op     = op_q;
    assign cfg.sew    = sew_q;
    assign cfg.amount = scalar_q;
    assign cfg.scalar = scalar_q;
    assign cfg.vl     = vl_q;

    a_penable_psel: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        penable_i |-> psel_i)
        else $error("penable without psel");

endmodule

/* design/sld_operand_fetch.sv */
// slide unit operand fetch
// captures a source vector and issues four beats of source word pairs
`include "sld_consts.svh"

module sld_operand_fetch
    import sld_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  logic                   src_valid_i,
    output logic                   src_ready_o,
    input  logic [`SLD_VREG_W-1:0] src_data_i,
    sld_cfg_if.engine              cfg,
    output logic                   beat_valid_o,
    output sld_beat_t              beat_o,
    input  logic                   beat_ready_i
);

    // source vector plus one word above it for the 1down scalar
    localparam int ext_w = `SLD_VREG_W + `SLD_OP_W;

    sld_fetch_state_e     state_q;
    logic [1:0]           beat_q;
    sld_op_e              op_q;
    sld_sew_e             sew_q;
    logic [`SLD_VL_W-1:0] vl_q;
    logic signed [5:0]    shift_q, shift_d;
    logic [ext_w-1:0]     ext_q, ext_d;
    logic [`SLD_OP_W-1:0] pre_q, pre_d;
    logic [2:0]           esize;
    logic [6:0]           vl_bytes;
    logic [4:0]           byte_sld;
    logic                 accept;
    logic signed [4:0]    lo_idx, hi_idx;
    logic [`SLD_OP_W:0]   lo_word, hi_word;

    assign src_ready_o  = (state_q == FETCH_IDLE);
    assign beat_valid_o = (state_q == FETCH_RUN);
    assign cfg.busy     = beat_valid_o;
    assign accept       = src_valid_i & src_ready_o;

    ////////////////////////////////////////////////////////////////////
    // slide amount in bytes

    assign esize    = sld_esize(cfg.sew);
    assign vl_bytes = sld_vl_bytes(cfg.vl, cfg.sew);

    always_comb begin
        if (cfg.op == SLD_1UP || cfg.op == SLD_1DOWN) begin
            byte_sld = 5'(esize);
        end else if ((cfg.amount >> (3'd4 - 3'(cfg.sew))) != '0) begin
            // whole register or more, saturate
            byte_sld = 5'd16;
        end else begin
            byte_sld = 5'(cfg.amount[3:0] << cfg.sew);
        end
        // signed byte shift, negative for up
        if (cfg.op == SLD_UP || cfg.op == SLD_1UP) begin
            shift_d = -$signed({1'b0, byte_sld});
        end else begin
            shift_d = $signed({1'b0, byte_sld});
        end
    end

    // scalar goes in as source element vl for 1down, or just below word 0 for 1up
    always_comb begin
        ext_d = {{`SLD_OP_W{1'b0}}, src_data_i};
        pre_d = cfg.scalar << (`SLD_OP_W - 8 * int'(esize));
        for (int p = 0; p < ext_w / 8; p++) begin
            if (cfg.op == SLD_1DOWN && p >= int'(vl_bytes) &&
                p < int'(vl_bytes) + int'(esize)) begin
                ext_d[8*p +: 8] = cfg.scalar[8*(p - int'(vl_bytes)) +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // control and capture

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= FETCH_IDLE;
            beat_q  <= '0;
        end else if (state_q == FETCH_IDLE) begin
            if (src_valid_i) begin
                state_q <= FETCH_RUN;
                beat_q  <= '0;
            end
        end else if (beat_ready_i) begin
            beat_q <= beat_q + 2'd1;
            if (beat_q == 2'(`SLD_BEATS - 1)) begin
                state_q <= FETCH_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q    <= cfg.op;
            sew_q   <= cfg.sew;
            vl_q    <= cfg.vl;
            shift_q <= shift_d;
            ext_q   <= ext_d;
            pre_q   <= pre_d;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // word pair selection

    // returns {valid, word} for a source word index
    function automatic logic [`SLD_OP_W:0] word_at(input logic signed [4:0] idx);
        if (idx < 0) begin
            // below the start, only the 1up scalar word is valid
            return {op_q == SLD_1UP && idx == -5'sd1, pre_q};
        end else if (idx <= 5'sd4) begin
            return {1'b1, ext_q[`SLD_OP_W*int'(idx) +: `SLD_OP_W]};
        end
        return {1'b1, {`SLD_OP_W{1'b0}}};
    endfunction

    // floor division of the byte shift gives the low word
    assign lo_idx  = $signed({3'b000, beat_q}) + $signed(shift_q[5:2]);
    assign hi_idx  = lo_idx + 5'sd1;
    assign lo_word = word_at(lo_idx);
    assign hi_word = word_at(hi_idx);

    always_comb begin
        beat_o.lo       = lo_word[`SLD_OP_W-1:0];
        beat_o.hi       = hi_word[`SLD_OP_W-1:0];
        beat_o.offset   = shift_q[1:0];
        beat_o.lo_valid = lo_word[`SLD_OP_W];
        beat_o.hi_valid = hi_word[`SLD_OP_W];
        beat_o.idx      = beat_q;
        beat_o.sew      = sew_q;
        beat_o.vl       = vl_q;
    end

    a_beat_order: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        beat_valid_o && beat_ready_i && beat_o.idx != 2'(`SLD_BEATS - 1)
        |=> beat_valid_o && beat_o.idx == $past(beat_o.idx) + 2'd1)
        else $error("beat index skipped within a vector");

endmodule

/* design/sld_byte_align.sv */
// slide unit byte aligner
// funnel-shifts a word pair into one result word and registers it
`include "sld_consts.svh"

module sld_byte_align
    import sld_pkg::*;
(
    input  logic      clk_i,
    input  logic      async_rst_ni,
    input  logic      beat_valid_i,
    input  sld_beat_t beat_i,
    output logic      beat_ready_o,
    output logic      lane_valid_o,
    output sld_lane_t lane_o,
    input  logic      lane_ready_i
);

    sld_lane_t lane_d, lane_q;
    logic      lane_valid_q;

    // take a beat when the stage is empty or drains this cycle
    assign beat_ready_o = !lane_valid_q || lane_ready_i;

    always_comb begin
        lane_d     = '0;
        lane_d.idx = beat_i.idx;
        lane_d.sew = beat_i.sew;
        lane_d.vl  = beat_i.vl;
        for (int i = 0; i < `SLD_OP_W / 8; i++) begin
            if (int'(beat_i.offset) + i < `SLD_OP_W / 8) begin
                lane_d.data[8*i +: 8] = beat_i.lo[8*(int'(beat_i.offset) + i) +: 8];
                lane_d.mask[i]        = beat_i.lo_valid;
            end else begin
                lane_d.data[8*i +: 8] = beat_i.hi[8*(int'(beat_i.offset) + i - 4) +: 8];
                lane_d.mask[i]        = beat_i.hi_valid;
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            lane_valid_q <= 1'b0;
        end else if (beat_ready_o) begin
            lane_valid_q <= beat_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_valid_i && beat_ready_o) begin
            lane_q <= lane_d;
        end
    end

    assign lane_valid_o = lane_valid_q;
    assign lane_o       = lane_q;

endmodule

/* design/sld_result_pack.sv */
// slide unit result packer
// gathers four lanes, applies the vl mask and holds the vector for the consumer
`include "sld_consts.svh"

module sld_result_pack
    import sld_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  logic                   lane_valid_i,
    input  sld_lane_t              lane_i,
    output logic                   lane_ready_o,
    output logic                   res_valid_o,
    input  logic                   res_ready_i,
    output logic [`SLD_VREG_W-1:0] res_data_o,
    output logic [`SLD_VMSK_W-1:0] res_mask_o,
    output logic                   result_done_o
);

    // lanes 0 to 2 wait here, lane 3 goes straight to the output
    logic [`SLD_VREG_W-`SLD_OP_W-1:0] asm_data_q;
    logic [`SLD_VMSK_W-5:0]           asm_mask_q;
    logic [`SLD_VREG_W-1:0]           res_data_q;
    logic [`SLD_VMSK_W-1:0]           res_mask_q;
    logic                             res_valid_q;
    logic [`SLD_VMSK_W-1:0]           vl_mask;
    logic [6:0]                       vl_bytes;
    logic                             last_lane;
    logic                             lane_take;
    logic                             load;

    assign last_lane    = (lane_i.idx == 2'(`SLD_BEATS - 1));
    assign lane_ready_o = !(res_valid_q && !res_ready_i && lane_valid_i && last_lane);
    assign lane_take    = lane_valid_i & lane_ready_o;
    assign load         = lane_take & last_lane;

    assign vl_bytes = sld_vl_bytes(lane_i.vl, lane_i.sew);

    always_comb begin
        for (int j = 0; j < `SLD_VMSK_W; j++) begin
            vl_mask[j] = (j < int'(vl_bytes));
        end
    end

    always_ff @(posedge clk_i) begin
        if (lane_take && !last_lane) begin
            asm_data_q[`SLD_OP_W*lane_i.idx +: `SLD_OP_W] <= lane_i.data;
            asm_mask_q[4*lane_i.idx +: 4]                 <= lane_i.mask;
        end
        if (load) begin
            res_data_q <= {lane_i.data, asm_data_q};
            res_mask_q <= {lane_i.mask, asm_mask_q} & vl_mask;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            res_valid_q <= 1'b0;
        end else if (load) begin
            res_valid_q <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_q <= 1'b0;
        end
    end

    assign res_valid_o   = res_valid_q;
    assign res_data_o    = res_data_q;
    assign res_mask_o    = res_mask_q;
    assign result_done_o = res_valid_q & res_ready_i;

    a_res_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        res_valid_o && !res_ready_i
        |=> res_valid_o && $stable(res_data_o) && $stable(res_mask_o))
        else $error("result changed under back-pressure");

endmodule

/* design/sld_top.sv */
// vector slide unit top level
// APB register block beside the fetch, align and pack datapath
`include "sld_consts.svh"

module sld_top
    import sld_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    // APB slave
    input  logic [`SLD_APB_AW-1:0] paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    // source vectors
    input  logic                   src_valid_i,
    output logic                   src_ready_o,
    input  logic [`SLD_VREG_W-1:0] src_data_i,
    // slid vectors with byte write mask
    output logic                   res_valid_o,
    input  logic                   res_ready_i,
    output logic [`SLD_VREG_W-1:0] res_data_o,
    output logic [`SLD_VMSK_W-1:0] res_mask_o
);

    sld_beat_t beat;
    sld_lane_t lane;
    logic      beat_valid, beat_ready;
    logic      lane_valid, lane_ready;
    logic      result_done;

    sld_cfg_if u_cfg ();

    sld_apb_regs u_regs (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .paddr_i       (paddr_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .result_done_i (result_done),
        .cfg           (u_cfg)
    );

    sld_operand_fetch u_fetch (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .src_valid_i  (src_valid_i),
        .src_ready_o  (src_ready_o),
        .src_data_i   (src_data_i),
        .cfg          (u_cfg),
        .beat_valid_o (beat_valid),
        .beat_o       (beat),
        .beat_ready_i (beat_ready)
    );

    sld_byte_align u_align (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .beat_valid_i (beat_valid),
        .beat_i       (beat),
        .beat_ready_o (beat_ready),
        .lane_valid_o (lane_valid),
        .lane_o       (lane),
        .lane_ready_i (lane_ready)
    );

    sld_result_pack u_pack (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .lane_valid_i  (lane_valid),
        .lane_i        (lane),
        .lane_ready_o  (lane_ready),
        .res_valid_o   (res_valid_o),
        .res_ready_i   (res_ready_i),
        .res_data_o    (res_data_o),
        .res_mask_o    (res_mask_o),
        .result_done_o (result_done)
    );

endmodule

/* testbench/sld_tb.sv */
// vector slide unit testbench
// programs the unit over APB, slides xorshift vectors and checks them against a byte model
`include "sld_consts.svh"

module sld_tb
    import sld_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // one table row; rs1 is the slide amount for up and down, the inserted value for 1up and 1down
    typedef struct packed {
        sld_op_e     op;
        sld_sew_e    sew;
        logic [31:0] rs1;
        logic [4:0]  vl;
        logic [3:0]  bp;
    } test_t;

    localparam int num_tests    = 20;
    localparam int reset_cycles = 10;
    localparam int max_cycles   = 40 * num_tests + reset_cycles;

    localparam test_t tests [num_tests] = '{
        // up and down at every width, full vl
        '{SLD_UP,    SEW_8,  32'd5,          5'd16, 4'd0},
        '{SLD_UP,    SEW_16, 32'd3,          5'd8,  4'd7},
        '{SLD_UP,    SEW_32, 32'd1,          5'd4,  4'd0},
        '{SLD_DOWN,  SEW_8,  32'd7,          5'd16, 4'd12},
        '{SLD_DOWN,  SEW_16, 32'd2,          5'd8,  4'd0},
        '{SLD_DOWN,  SEW_32, 32'd2,          5'd4,  4'd5},
        // single slides with a scalar
        '{SLD_1UP,   SEW_8,  32'h0000_00a5,  5'd16, 4'd0},
        '{SLD_1UP,   SEW_16, 32'h1234_beef,  5'd8,  4'd9},
        '{SLD_1UP,   SEW_32, 32'hdead_beef,  5'd4,  4'd0},
        '{SLD_1DOWN, SEW_8,  32'h0000_005a,  5'd16, 4'd3},
        '{SLD_1DOWN, SEW_16, 32'h0000_c3d2,  5'd8,  4'd0},
        '{SLD_1DOWN, SEW_32, 32'hcafe_f00d,  5'd4,  4'd12},
        // short vl, zero vl and overflow
        '{SLD_UP,    SEW_8,  32'd3,          5'd9,  4'd0},
        '{SLD_DOWN,  SEW_16, 32'd1,          5'd5,  4'd6},
        '{SLD_1DOWN, SEW_32, 32'h0bad_f00d,  5'd3,  4'd0},
        '{SLD_1UP,   SEW_16, 32'h0000_7e57,  5'd0,  4'd4},
        '{SLD_UP,    SEW_16, 32'd9,          5'd8,  4'd0},
        '{SLD_DOWN,  SEW_8,  32'd20,         5'd16, 4'd10},
        '{SLD_DOWN,  SEW_32, 32'h8000_0000,  5'd4,  4'd0},
        '{SLD_1DOWN, SEW_8,  32'h0000_0081,  5'd6,  4'd11}
    };

    logic                   clk_i;
    logic                   async_rst_ni;
    logic [`SLD_APB_AW-1:0] paddr_i;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    logic [31:0]            pwdata_i;
    logic [31:0]            prdata_o;
    logic                   pready_o;
    logic                   pslverr_o;
    logic                   src_valid_i;
    logic                   src_ready_o;
    logic [`SLD_VREG_W-1:0] src_data_i;
    logic                   res_valid_o;
    logic                   res_ready_i;
    logic [`SLD_VREG_W-1:0] res_data_o;
    logic [`SLD_VMSK_W-1:0] res_mask_o;

    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    int          test_no = 0;
    int          delivered = 0;
    int          cycle_cnt = 0;
    logic [31:0] rng_state = 32'h4ca7;

    sld_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // watchdog
    initial begin
        while (cycle_cnt < max_cycles) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic report_mismatch(input string sig, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("ERROR at %0d ns: %s = %0h, expected %0h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic close_test(input string desc, input int errs_before);
        test_no++;
        if (errors == errs_before) begin
            passed++;
            $display("test %2d %s: PASS", test_no, desc);
        end else begin
            failed++;
            $display("test %2d %s: FAIL", test_no, desc);
        end
    endtask

    task automatic apb_write(input logic [`SLD_APB_AW-1:0] addr, input logic [31:0] data);
        tick();
        paddr_i  = addr;
        pwdata_i = data;
        pwrite_i = 1'b1;
        psel_i   = 1'b1;
        tick();
        penable_i = 1'b1;
        tick();
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input logic [`SLD_APB_AW-1:0] addr, output logic [31:0] data);
        tick();
        paddr_i  = addr;
        pwrite_i = 1'b0;
        psel_i   = 1'b1;
        tick();
        penable_i = 1'b1;
        @(negedge clk_i);
        data = prdata_o;
        if (pready_o !== 1'b1) report_mismatch("pready_o", pready_o, 1'b1);
        if (pslverr_o !== 1'b0) report_mismatch("pslverr_o", pslverr_o, 1'b0);
        tick();
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic send_vector(input logic [`SLD_VREG_W-1:0] v);
        tick();
        src_valid_i = 1'b1;
        src_data_i  = v;
        @(negedge clk_i);
        while (!src_ready_o) @(negedge clk_i);
        tick();
        src_valid_i = 1'b0;
    endtask

    // waits for a result, holds ready low for hold cycles, then takes it
    task automatic take_result(input int hold, output logic [`SLD_VREG_W-1:0] d,
                               output logic [`SLD_VMSK_W-1:0] m);
        @(negedge clk_i);
        while (!res_valid_o) @(negedge clk_i);
        d = res_data_o;
        m = res_mask_o;
        repeat (hold) begin
            @(negedge clk_i);
            if (res_valid_o !== 1'b1) report_mismatch("res_valid_o", res_valid_o, 1'b1);
            if (res_data_o !== d) report_mismatch("res_data_o held", res_data_o, d);
            if (res_mask_o !== m) report_mismatch("res_mask_o held", res_mask_o, m);
        end
        tick();
        res_ready_i = 1'b1;
        tick();
        res_ready_i = 1'b0;
        delivered++;
        @(negedge clk_i);
        // a second copy must not follow
        if (res_valid_o !== 1'b0) report_mismatch("res_valid_o after take", res_valid_o, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // byte reference model

    function automatic void slide_model(input sld_op_e op, input sld_sew_e sew,
                                        input logic [31:0] rs1, input int vl,
                                        input logic [127:0] src,
                                        output logic [127:0] exp_data,
                                        output logic [15:0] exp_mask);
        int esize;
        int vlb;
        int s;
        case (sew)
            SEW_8:   esize = 1;
            SEW_16:  esize = 2;
            default: esize = 4;
        endcase
        vlb = vl * esize;
        if (op == SLD_1UP || op == SLD_1DOWN) begin
            s = esize;
        end else if (rs1 >= 32'(16 / esize)) begin
            s = 16;
        end else begin
            s = int'(rs1) * esize;
        end
        exp_data = '0;
        exp_mask = '0;
        for (int j = 0; j < 16; j++) begin
            if (op == SLD_UP || op == SLD_1UP) begin
                if (j >= s) begin
                    exp_data[8*j +: 8] = src[8*(j - s) +: 8];
                    exp_mask[j]        = 1'b1;
                end else if (op == SLD_1UP) begin
                    exp_data[8*j +: 8] = rs1[8*j +: 8];
                    exp_mask[j]        = 1'b1;
                end
            end else begin
                exp_mask[j] = 1'b1;
                // 1down puts the scalar into element vl-1
                if (op == SLD_1DOWN && j >= vlb - esize && j < vlb) begin
                    exp_data[8*j +: 8] = rs1[8*(j - vlb + esize) +: 8];
                end else if (j + s < 16) begin
                    exp_data[8*j +: 8] = src[8*(j + s) +: 8];
                end
            end
            if (j >= vlb) exp_mask[j] = 1'b0;
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        test_t        entry;
        sld_op_e      op;
        sld_sew_e     sew;
        logic [127:0] src;
        logic [127:0] got_data;
        logic [127:0] exp_data;
        logic [127:0] keep;
        logic [15:0]  got_mask;
        logic [15:0]  exp_mask;
        logic [31:0]  rd;
        int           hold;
        int           errs_before;

        async_rst_ni = 1'b0;
        paddr_i      = '0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        pwdata_i     = '0;
        src_valid_i  = 1'b0;
        src_data_i   = '0;
        res_ready_i  = 1'b0;
        repeat (reset_cycles) @(posedge clk_i);
        #1 async_rst_ni = 1'b1;

        // state after reset
        errs_before = errors;
        @(negedge clk_i);
        if (src_ready_o !== 1'b1) report_mismatch("src_ready_o", src_ready_o, 1'b1);
        if (res_valid_o !== 1'b0) report_mismatch("res_valid_o", res_valid_o, 1'b0);
        apb_read(`SLD_REG_CTRL, rd);
        if (rd !== 32'd0) report_mismatch("CTRL", rd, 32'd0);
        apb_read(`SLD_REG_SCALAR, rd);
        if (rd !== 32'd0) report_mismatch("SCALAR", rd, 32'd0);
        apb_read(`SLD_REG_VL, rd);
        if (rd !== 32'd0) report_mismatch("VL", rd, 32'd0);
        apb_read(`SLD_REG_STATUS, rd);
        if (rd !== 32'd0) report_mismatch("STATUS", rd, 32'd0);
        // reserved width code 3 keeps the old sew, op still changes
        apb_write(`SLD_REG_CTRL, 32'h0000_000d);
        apb_read(`SLD_REG_CTRL, rd);
        if (rd !== 32'h0000_0001) report_mismatch("CTRL", rd, 32'h0000_0001);
        close_test("reset and registers", errs_before);

        for (int t = 0; t < num_tests; t++) begin
            errs_before = errors;
            entry = tests[t];
            op    = entry.op;
            sew   = entry.sew;
            for (int w = 0; w < 4; w++) begin
                rng_state        = xorshift32(rng_state);
                src[32*w +: 32]  = rng_state;
            end
            rng_state = xorshift32(rng_state);
            hold = (entry.bp == 4'd0) ? 0 : int'(rng_state % (32'(entry.bp) + 32'd1));

            apb_write(`SLD_REG_SCALAR, entry.rs1);
            apb_write(`SLD_REG_VL, {27'd0, entry.vl});
            apb_write(`SLD_REG_CTRL, {28'd0, entry.sew, entry.op});
            slide_model(op, sew, entry.rs1, int'(entry.vl), src, exp_data, exp_mask);

            send_vector(src);
            take_result(hold, got_data, got_mask);

            for (int j = 0; j < 16; j++) begin
                keep[8*j +: 8] = {8{exp_mask[j]}};
            end
            if (got_mask !== exp_mask) report_mismatch("res_mask_o", got_mask, exp_mask);
            if ((got_data & keep) !== (exp_data & keep)) begin
                report_mismatch("res_data_o", got_data & keep, exp_data & keep);
            end
            apb_read(`SLD_REG_STATUS, rd);
            if (rd !== {16'd0, 8'(delivered), 8'd0}) begin
                report_mismatch("STATUS", rd, {16'd0, 8'(delivered), 8'd0});
            end
            close_test($sformatf("%-9s %-6s rs1=%h vl=%0d hold=%0d", op.name(), sew.name(),
                                 entry.rs1, entry.vl, hold), errs_before);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_no, passed, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+design
design/sld_pkg.sv
design/sld_cfg_if.sv
design/sld_apb_regs.sv
design/sld_operand_fetch.sv
design/sld_byte_align.sv
design/sld_result_pack.sv
design/sld_top.sv
testbench/sld_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the slide unit testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module sld_tb -Mdir obj_dir -f sim.f
./obj_dir/Vsld_tb 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
